/* Makefile */
TOP = tb_udp_capture

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@if grep -q "TB FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TB PASSED" sim.log || (echo "Simulation did not complete"; exit 1)

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir sim.log

/* rtl/adc_sampler.sv */
module adc_sampler (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start,
    input  logic                                 stop,
    input  logic [udp_capture_pkg::ADC_WIDTH-1:0] x,
    output logic                                 adc_clk,
    output logic                                 wr_en,
    output udp_capture_pkg::byte_beat_t          wr_beat
);

    import udp_capture_pkg::*;

    logic                 run;
    logic                 run_d;
    logic                 stop_pend;
    logic [DIV_W-1:0]     div;
    logic [DIV_W-1:0]     div_d;
    logic [SMP_W-1:0]     smp_cnt;
    logic [7:0]           smp_lo;
    logic                 lo_pend;
    logic                 lo_last;
    logic                 halt;
    logic                 tick;

    // Stop only takes effect on a frame boundary
    assign halt = (stop_pend || stop) && (smp_cnt == '0);

    always_comb begin
        run_d = run;
        div_d = div;
        if (!run) begin
            run_d = start;
            div_d = '0;
        end else if (div == DIV_W'(ADC_DIV - 1)) begin
            run_d = !halt;
            div_d = '0;
        end else begin
            div_d = div + 1'b1;
        end
    end

    // Rising edge of adc_clk
    assign tick = run_d && (div_d == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            run       <= 1'b0;
            stop_pend <= 1'b0;
            div       <= '0;
            smp_cnt   <= '0;
            adc_clk   <= 1'b0;
            wr_en     <= 1'b0;
            lo_pend   <= 1'b0;
        end else begin
            run     <= run_d;
            div     <= div_d;
            adc_clk <= run_d && (div_d < DIV_W'(ADC_DIV / 2));
            wr_en   <= tick || lo_pend;
            lo_pend <= tick;
            if (!run) begin
                stop_pend <= 1'b0;
            end else if (stop) begin
                stop_pend <= 1'b1;
            end
            if (tick) begin
                smp_cnt <= (smp_cnt == SMP_W'(SAMPLES_PER_FRAME - 1)) ? '0 : smp_cnt + 1'b1;
            end
        end
    end

    // Sample capture and byte formatting
    always_ff @(posedge clk) begin
        if (tick) begin
            smp_lo       <= x[7:0];
            lo_last      <= (smp_cnt == SMP_W'(SAMPLES_PER_FRAME - 1));
            wr_beat.data <= {{(16 - ADC_WIDTH){1'b0}}, x[ADC_WIDTH-1:8]};
            wr_beat.last <= 1'b0;
        end else if (lo_pend) begin
            wr_beat.data <= smp_lo;
            wr_beat.last <= lo_last;
        end
    end

endmodule

/* rtl/frame_fifo.sv */
module frame_fifo (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wr_en,
    input  udp_capture_pkg::byte_beat_t wr_beat,
    output logic                        rd_valid,
    input  logic                        rd_ready,
    output udp_capture_pkg::byte_beat_t rd_beat,
    output logic                        overflow
);

    import udp_capture_pkg::*;

    byte_beat_t mem [FIFO_DEPTH];

    // One extra bit to tell full from empty
    logic [FIFO_AW:0] wr_ptr;
    logic [FIFO_AW:0] cmt_ptr;
    logic [FIFO_AW:0] rd_ptr;
    logic             drop;
    logic             full;
    logic             do_write;

    assign full = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                  (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

    // Only committed frames are visible to the reader
    assign rd_valid = (cmt_ptr != rd_ptr);
    assign rd_beat  = mem[rd_ptr[FIFO_AW-1:0]];

    assign do_write = wr_en && !drop && !full;

    //////////////////////////////
    // Write side
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            cmt_ptr  <= '0;
            drop     <= 1'b0;
            overflow <= 1'b0;
        end else begin
            overflow <= 1'b0;
            if (wr_en) begin
                if (drop) begin
                    // Skip the rest of a dropped frame
                    if (wr_beat.last) begin
                        drop <= 1'b0;
                    end
                end else if (full) begin
                    wr_ptr   <= cmt_ptr;
                    overflow <= 1'b1;
                    drop     <= !wr_beat.last;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (wr_beat.last) begin
                        cmt_ptr <= wr_ptr + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= wr_beat;
        end
    end

    //////////////////////////////
    // Read side
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (rd_valid && rd_ready) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

/* rtl/status_display.sv */
module status_display (
    input  logic       clk,
    input  logic       rst,
    input  logic       hdr_start,
    input  logic       pay_first,
    input  logic [7:0] pay_byte,
    output logic [8:0] ledg,
    output logic [6:0] hex0,
    output logic [6:0] hex1,
    output logic [6:0] hex2,
    output logic [6:0] hex3,
    output logic [6:0] hex4,
    output logic [6:0] hex5,
    output logic [6:0] hex6,
    output logic [6:0] hex7
);

    import udp_capture_pkg::*;

    logic [31:0] ip_q;

    // Active-low segments, a in bit 0
    function automatic logic [6:0] seg7_inv(input logic [3:0] nib);
        logic [6:0] seg;
        case (nib)
            4'h0: seg = 7'h3f;
            4'h1: seg = 7'h06;
            4'h2: seg = 7'h5b;
            4'h3: seg = 7'h4f;
            4'h4: seg = 7'h66;
            4'h5: seg = 7'h6d;
            4'h6: seg = 7'h7d;
            4'h7: seg = 7'h07;
            4'h8: seg = 7'h7f;
            4'h9: seg = 7'h6f;
            4'ha: seg = 7'h77;
            4'hb: seg = 7'h7c;
            4'hc: seg = 7'h39;
            4'hd: seg = 7'h5e;
            4'he: seg = 7'h79;
            default: seg = 7'h71;
        endcase
        return ~seg;
    endfunction

    // First payload byte of the frame in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            ledg <= '0;
        end else if (pay_first) begin
            ledg <= {1'b0, pay_byte};
        end
    end

    // Destination address seen at frame start
    always_ff @(posedge clk) begin
        if (rst) begin
            ip_q <= '0;
        end else if (hdr_start) begin
            ip_q <= DEST_IP;
        end
    end

    assign hex0 = seg7_inv(ip_q[3:0]);
    assign hex1 = seg7_inv(ip_q[7:4]);
    assign hex2 = seg7_inv(ip_q[11:8]);
    assign hex3 = seg7_inv(ip_q[15:12]);
    assign hex4 = seg7_inv(ip_q[19:16]);
    assign hex5 = seg7_inv(ip_q[23:20]);
    assign hex6 = seg7_inv(ip_q[27:24]);
    assign hex7 = seg7_inv(ip_q[31:28]);

endmodule

/* rtl/udp_capture_pkg.sv */
package udp_capture_pkg;

    //////////////////////////////
    // Sampling and framing sizes
    //////////////////////////////

    localparam int ADC_WIDTH         = 10;
    localparam int ADC_DIV           = 4;
    localparam int SAMPLES_PER_FRAME = 3;
    localparam int PAYLOAD_BYTES     = 6;
    localparam int HEADER_BYTES      = 42;
    localparam int FRAME_BYTES       = HEADER_BYTES + PAYLOAD_BYTES;
    localparam int FIFO_DEPTH        = 16;

    // Counter and pointer widths
    localparam int DIV_W  = $clog2(ADC_DIV);
    localparam int SMP_W  = $clog2(SAMPLES_PER_FRAME);
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);
    localparam int IDX_W  = $clog2(FRAME_BYTES);

    //////////////////////////////
    // Addressing
    //////////////////////////////

    localparam logic [47:0] LOCAL_MAC = 48'h02_00_00_00_00_00;
    localparam logic [47:0] DEST_MAC  = 48'hc8_a3_62_c9_95_7b;
    localparam logic [31:0] LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [31:0] DEST_IP   = {8'd192, 8'd168, 8'd1, 8'd100};
    localparam logic [15:0] SRC_PORT  = 16'd1234;
    localparam logic [15:0] DST_PORT  = 16'd5678;

    localparam logic [7:0]  IP_TTL         = 8'd64;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

    // IP header + UDP header + payload, then UDP header + payload
    localparam logic [15:0] IP_TOTAL_LEN = 16'd34;
    localparam logic [15:0] UDP_LEN      = 16'd14;

    // One byte of a stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } byte_beat_t;

    typedef enum logic [1:0] {
        st_idle,
        st_header,
        st_payload
    } framer_state_t;

    // One's-complement sum over the ten IPv4 header words
    function automatic logic [15:0] ip_checksum();
        logic [31:0] sum;
        sum = 32'h0000_4500;
        sum = sum + {16'h0, IP_TOTAL_LEN};
        // Identification, flags/offset and the checksum word add nothing
        sum = sum + {16'h0, IP_TTL, IP_PROTO_UDP};
        sum = sum + {16'h0, LOCAL_IP[31:16]};
        sum = sum + {16'h0, LOCAL_IP[15:0]};
        sum = sum + {16'h0, DEST_IP[31:16]};
        sum = sum + {16'h0, DEST_IP[15:0]};
        // Fold carries back in twice
        sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        return ~sum[15:0];
    endfunction

    // Byte i of the Ethernet/IPv4/UDP header, big-endian fields
    function automatic logic [7:0] header_byte(input logic [IDX_W-1:0] i);
        logic [HEADER_BYTES*8-1:0] hdr;
        hdr = {DEST_MAC, LOCAL_MAC, ETHERTYPE_IPV4,
               8'h45, 8'h00, IP_TOTAL_LEN, 32'h0000_0000,
               IP_TTL, IP_PROTO_UDP, ip_checksum(),
               LOCAL_IP, DEST_IP,
               SRC_PORT, DST_PORT, UDP_LEN, 16'h0000};
        if (i < IDX_W'(HEADER_BYTES)) begin
            return hdr[(HEADER_BYTES - 1 - int'(i)) * 8 +: 8];
        end
        return 8'h00;
    endfunction

endpackage

/* rtl/udp_capture_top.sv */
module udp_capture_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [udp_capture_pkg::ADC_WIDTH-1:0] x,
    input  logic                                  start,
    input  logic                                  stop,
    output logic                                  adc_clk,
    output logic                                  tx_valid,
    input  logic                                  tx_ready,
    output udp_capture_pkg::byte_beat_t           tx_beat,
    output logic                                  overflow,
    output logic [8:0]                            ledg,
    output logic [6:0]                            hex0,
    output logic [6:0]                            hex1,
    output logic [6:0]                            hex2,
    output logic [6:0]                            hex3,
    output logic [6:0]                            hex4,
    output logic [6:0]                            hex5,
    output logic [6:0]                            hex6,
    output logic [6:0]                            hex7
);

    import udp_capture_pkg::*;

    // Sampler to FIFO
    logic       wr_en;
    byte_beat_t wr_beat;

    // FIFO to framer
    logic       rd_valid;
    logic       rd_ready;
    byte_beat_t rd_beat;

    // Framer to status
    logic       hdr_start;
    logic       pay_first;
    logic [7:0] pay_byte;

    adc_sampler u_sampler (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .stop    (stop),
        .x       (x),
        .adc_clk (adc_clk),
        .wr_en   (wr_en),
        .wr_beat (wr_beat)
    );

    frame_fifo u_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_beat  (wr_beat),
        .rd_valid (rd_valid),
        .rd_ready (rd_ready),
        .rd_beat  (rd_beat),
        .overflow (overflow)
    );

    udp_tx_framer u_framer (
        .clk       (clk),
        .rst       (rst),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_beat   (rd_beat),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .tx_beat   (tx_beat),
        .hdr_start (hdr_start),
        .pay_first (pay_first),
        .pay_byte  (pay_byte)
    );

    status_display u_status (
        .clk       (clk),
        .rst       (rst),
        .hdr_start (hdr_start),
        .pay_first (pay_first),
        .pay_byte  (pay_byte),
        .ledg      (ledg),
        .hex0      (hex0),
        .hex1      (hex1),
        .hex2      (hex2),
        .hex3      (hex3),
        .hex4      (hex4),
        .hex5      (hex5),
        .hex6      (hex6),
        .hex7      (hex7)
    );

endmodule

/* rtl/udp_tx_framer.sv */
module udp_tx_framer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rd_valid,
    output logic                        rd_ready,
    input  udp_capture_pkg::byte_beat_t rd_beat,
    output logic                        tx_valid,
    input  logic                        tx_ready,
    output udp_capture_pkg::byte_beat_t tx_beat,
    output logic                        hdr_start,
    output logic                        pay_first,
    output logic [7:0]                  pay_byte
);

    import udp_capture_pkg::*;

    framer_state_t    state;
    logic [IDX_W-1:0] idx;
    logic             accept;

    //////////////////////////////
    // Output stream
    //////////////////////////////

    // Header bytes are always ready; payload follows the FIFO
    assign tx_valid = (state == st_header) || ((state == st_payload) && rd_valid);
    assign rd_ready = (state == st_payload) && tx_ready;
    assign accept   = tx_valid && tx_ready;

    // Both sources only change on an accepted beat, so the beat holds
    always_comb begin
        if (state == st_header) begin
            tx_beat.data = header_byte(idx);
            tx_beat.last = 1'b0;
        end else begin
            tx_beat = rd_beat;
        end
    end

    // Status strobes
    assign hdr_start = accept && (state == st_header) && (idx == '0);
    assign pay_first = accept && (state == st_payload) && (idx == IDX_W'(HEADER_BYTES));
    assign pay_byte  = rd_beat.data;

    //////////////////////////////
    // Frame FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            idx   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (rd_valid) begin
                        state <= st_header;
                        idx   <= '0;
                    end
                end

                st_header: begin
                    if (accept) begin
                        idx <= idx + 1'b1;
                        if (idx == IDX_W'(HEADER_BYTES - 1)) begin
                            state <= st_payload;
                        end
                    end
                end

                st_payload: begin
                    // A committed frame is complete, so no gaps here
                    if (accept) begin
                        if (rd_beat.last) begin
                            state <= st_idle;
                            idx   <= '0;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end

                default: begin
                    state <= st_idle;
                    idx   <= '0;
                end
            endcase
        end
    end

endmodule

/* sim.f */
rtl/udp_capture_pkg.sv
rtl/adc_sampler.sv
rtl/frame_fifo.sv
rtl/udp_tx_framer.sv
rtl/status_display.sv
rtl/udp_capture_top.sv
tests/udp_capture_chk.sv
tests/tb_udp_capture.sv

/* tests/tb_udp_capture.sv */
module tb_udp_capture;

    import udp_capture_pkg::*;

    localparam int FRAME_LEN      = 48;
    localparam int NUM_FRAMES     = 9;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_LEN * 4 + 1000;
    localparam int READY_HIGH     = 0;
    localparam int READY_RANDOM   = 1;
    localparam int READY_LOW      = 2;
    localparam logic [31:0] DST_IP_REF = 32'hc0a8_0164;

    logic                 clk = 1'b0;
    logic                 rst = 1'b1;
    logic                 start = 1'b0;
    logic                 stop = 1'b0;
    logic [ADC_WIDTH-1:0] x = '0;
    logic                 tx_ready = 1'b0;
    logic                 adc_clk;
    logic                 tx_valid;
    byte_beat_t           tx_beat;
    logic                 overflow;
    logic [8:0]           ledg;
    logic [6:0]           hex [8];

    integer               seed = 11242;
    logic [31:0]          rnd;
    logic                 adc_prev = 1'b0;
    int                   ready_mode = READY_HIGH;
    logic [ADC_WIDTH-1:0] samples [$];
    int                   sample_count = 0;
    bit                   dropped [int];
    int                   errors = 0;
    int                   frames_rx = 0;
    int                   ovf_count = 0;
    int                   beat_pos = 0;
    int                   next_frame = 0;
    logic [FRAME_LEN*8-1:0] exp_frame = '0;

    udp_capture_top dut (
        .clk      (clk),
        .rst      (rst),
        .x        (x),
        .start    (start),
        .stop     (stop),
        .adc_clk  (adc_clk),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_beat  (tx_beat),
        .overflow (overflow),
        .ledg     (ledg),
        .hex0     (hex[0]),
        .hex1     (hex[1]),
        .hex2     (hex[2]),
        .hex3     (hex[3]),
        .hex4     (hex[4]),
        .hex5     (hex[5]),
        .hex6     (hex[6]),
        .hex7     (hex[7])
    );

    always #5 clk = ~clk;

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Active-low digit patterns, segment a in bit 0
    function automatic logic [6:0] seg_ref(input logic [3:0] nib);
        logic [6:0] pat;
        case (nib)
            4'h0: pat = 7'h40;
            4'h1: pat = 7'h79;
            4'h2: pat = 7'h24;
            4'h3: pat = 7'h30;
            4'h4: pat = 7'h19;
            4'h5: pat = 7'h12;
            4'h6: pat = 7'h02;
            4'h7: pat = 7'h78;
            4'h8: pat = 7'h00;
            4'h9: pat = 7'h10;
            4'ha: pat = 7'h08;
            4'hb: pat = 7'h03;
            4'hc: pat = 7'h46;
            4'hd: pat = 7'h21;
            4'he: pat = 7'h06;
            default: pat = 7'h0e;
        endcase
        return pat;
    endfunction

    // Ethernet + IPv4 + UDP header, checksum summed over the IP words
    function automatic logic [335:0] header_ref();
        logic [335:0] h;
        logic [31:0]  sum;
        h = {48'hc8a3_62c9_957b, 48'h0200_0000_0000, 16'h0800,
             8'h45, 8'h00, 16'd34, 32'h0, 8'd64, 8'd17, 16'h0000,
             8'd192, 8'd168, 8'd1, 8'd128, DST_IP_REF,
             16'd1234, 16'd5678, 16'd14, 16'h0000};
        sum = '0;
        for (int k = 0; k < 10; k++) begin
            sum = sum + {16'h0, h[335 - (14 + 2 * k) * 8 -: 16]};
        end
        while (sum[31:16] != 16'h0) begin
            sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        end
        h[335 - 24 * 8 -: 16] = ~sum[15:0];
        return h;
    endfunction

    function automatic logic [FRAME_LEN*8-1:0] ref_frame(input logic [9:0] s0,
                                                         input logic [9:0] s1,
                                                         input logic [9:0] s2);
        return {header_ref(), 6'b0, s0, 6'b0, s1, 6'b0, s2};
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s expected 0x%0h actual 0x%0h at time %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("Failure at time %0t: %s", $time, what);
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // x moves only after a sample edge, so the recorded value is the sampled one
    always @(posedge clk) begin
        #1;
        if (adc_clk && !adc_prev) begin
            samples.push_back(x);
            sample_count++;
            rnd = $random(seed);
            x = rnd[ADC_WIDTH-1:0];
        end
        adc_prev = adc_clk;
        case (ready_mode)
            READY_HIGH: tx_ready = 1'b1;
            READY_RANDOM: begin
                rnd = $random(seed);
                tx_ready = (rnd[1:0] != 2'b00);
            end
            default: tx_ready = 1'b0;
        endcase
    end

    // Run the sampler for n complete frames
    task automatic capture(input int n);
        int base;
        base = sample_count;
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        wait (sample_count >= base + 3 * n - 2);
        @(posedge clk);
        #1 stop = 1'b1;
        @(posedge clk);
        #1 stop = 1'b0;
        wait (sample_count >= base + 3 * n);
        repeat (4) @(posedge clk);
    endtask

    //////////////////////////////
    // Monitor and scoreboard
    //////////////////////////////

    always @(negedge clk) begin
        if (!rst) begin
            // Overflow belongs to the frame of the newest sample
            if (overflow) begin
                ovf_count++;
                dropped[(sample_count - 1) / 3] = 1'b1;
            end
            if (tx_valid && tx_ready) begin
                if (beat_pos == 0) begin
                    while (dropped.exists(next_frame)) begin
                        next_frame++;
                    end
                    if (sample_count < 3 * (next_frame + 1)) begin
                        note_failure("a frame started before its samples were taken");
                        exp_frame = '0;
                    end else begin
                        exp_frame = ref_frame(samples[3 * next_frame],
                                              samples[3 * next_frame + 1],
                                              samples[3 * next_frame + 2]);
                    end
                end
                check("tx_beat.data", 32'(exp_frame[383 - 8 * beat_pos -: 8]),
                      32'(tx_beat.data));
                check("tx_beat.last", 32'(beat_pos == FRAME_LEN - 1), 32'(tx_beat.last));
                if (beat_pos == FRAME_LEN - 1) begin
                    check("ledg", {24'h0, exp_frame[383 - 8 * 42 -: 8]}, 32'(ledg));
                    for (int k = 0; k < 8; k++) begin
                        check($sformatf("hex%0d", k), 32'(seg_ref(DST_IP_REF[4 * k +: 4])),
                              32'(hex[k]));
                    end
                    frames_rx++;
                    next_frame++;
                    beat_pos = 0;
                end else begin
                    beat_pos++;
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with %0d frames received and %0d errors",
                 TIMEOUT_CYCLES, frames_rx, errors);
        $display("TB FAILED");
        $finish;
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        check("tx_valid", 32'h0, 32'(tx_valid));
        check("adc_clk", 32'h0, 32'(adc_clk));
        check("overflow", 32'h0, 32'(overflow));
        check("ledg", 32'h0, 32'(ledg));
        for (int k = 0; k < 8; k++) begin
            check($sformatf("hex%0d", k), 32'(seg_ref(4'h0)), 32'(hex[k]));
        end

        // Free-running sink
        capture(2);
        wait (frames_rx >= 2);

        // Random back-pressure
        ready_mode = READY_RANDOM;
        capture(2);
        wait (frames_rx >= 4);

        // Stalled sink fills the FIFO
        ready_mode = READY_LOW;
        capture(5);
        if (ovf_count == 0) begin
            note_failure("the FIFO never reported an overflow while the output was stalled");
        end
        ready_mode = READY_HIGH;
        wait (frames_rx >= NUM_FRAMES - dropped.num());
        repeat (60) @(posedge clk);
        check("frames_rx", 32'(NUM_FRAMES - dropped.num()), 32'(frames_rx));
        check("tx_valid", 32'h0, 32'(tx_valid));
        if (dut.u_framer.u_chk.fails != 0 || dut.u_fifo.u_chk.fails != 0) begin
            note_failure("a stream or pulse assertion fired during the run");
        end

        $display("errors: %0d  frames: %0d  overflows: %0d", errors, frames_rx, ovf_count);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* tests/udp_capture_chk.sv */
module udp_capture_chk (
    input logic                        clk,
    input logic                        rst,
    input logic                        valid,
    input logic                        ready,
    input udp_capture_pkg::byte_beat_t beat,
    input logic                        pulse
);

    int fails = 0;

    // A stalled beat stays put
    hold_beat: assert property (@(posedge clk) disable iff (rst)
        valid && !ready |=> valid && $stable(beat))
    else begin
        fails++;
        $error("stream beat changed while stalled");
    end

    // Status pulses last one cycle
    single_pulse: assert property (@(posedge clk) disable iff (rst)
        pulse |=> !pulse)
    else begin
        fails++;
        $error("pulse held for more than one cycle");
    end

    no_valid_in_reset: assert property (@(posedge clk)
        rst |=> !valid)
    else begin
        fails++;
        $error("stream valid high after a reset cycle");
    end

endmodule

bind udp_tx_framer udp_capture_chk u_chk (
    .clk   (clk),
    .rst   (rst),
    .valid (tx_valid),
    .ready (tx_ready),
    .beat  (tx_beat),
    .pulse (hdr_start)
);

bind frame_fifo udp_capture_chk u_chk (
    .clk   (clk),
    .rst   (rst),
    .valid (rd_valid),
    .ready (rd_ready),
    .beat  (rd_beat),
    .pulse (overflow)
);
